// ==== Bender.yml ====
package:
  name: sa_array

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/sa_types_pkg.sv
      - hw/sa_regs_pkg.sv
      - hw/sa_controller.sv
      - hw/sa_mac_array.sv
      - hw/psum_adder.sv
      - hw/sa_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/sa_tb.sv

// ==== flist.f ====
+incdir+include
hw/sa_types_pkg.sv
hw/sa_regs_pkg.sv
hw/sa_controller.sv
hw/sa_mac_array.sv
hw/psum_adder.sv
hw/sa_top.sv
sim/sa_tb.sv

// ==== hw/psum_adder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sa_settings.svh"

module psum_adder (
  input  logic                  clk,
  input  logic                  rst,
  input  sa_types_pkg::y_beat_t col,
  input  logic                  col_valid,
  output logic                  col_ready,
  input  sa_types_pkg::a_beat_t a,
  input  logic                  a_valid,
  output logic                  a_ready,
  output sa_types_pkg::y_beat_t y,
  output logic                  y_valid,
  input  logic                  y_ready
);

  logic room;
  logic take;

  // Output slot free or leaving this cycle
  assign room      = !y_valid || y_ready;
  assign col_ready = room && a_valid;
  assign a_ready   = room && col_valid;
  assign take      = room && col_valid && a_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      y_valid <= 1'b0;
    end else if (take) begin
      y_valid <= 1'b1;
    end else if (y_ready) begin
      y_valid <= 1'b0;
    end
  end

  // Sums wrap to the accumulator width
  always_ff @(posedge clk) begin
    if (take) begin
      for (int r = 0; r < `SA_R; r++) begin
        y.data[r] <= col.data[r] + a[r];
      end
      y.last <= col.last;
    end
  end

  a_y_hold: assert property (
    @(posedge clk) disable iff (rst)
    (y_valid && !y_ready) |=> (y_valid && $stable(y))
  ) else $error("y beat changed under back-pressure at %0t", $time);

endmodule

`default_nettype wire

// ==== hw/sa_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module sa_controller (
  input  logic                 clk,
  input  logic                 rst,
  input  sa_regs_pkg::wb_req_t wb_req,
  output sa_regs_pkg::wb_rsp_t wb_rsp,
  input  logic                 busy,
  input  logic                 mismatch,
  input  logic                 tile_done,
  output logic                 run
);

  import sa_regs_pkg::*;

  logic        ack;
  logic        req;
  logic        wr;
  logic        mismatch_flag;
  logic [15:0] tiles;
  logic [31:0] rdata;
  logic [31:0] rd_q;

  // New cycle seen, not yet acknowledged
  assign req = wb_req.cyc && wb_req.stb && !ack;

  // Only the low byte holds writable bits
  assign wr = req && wb_req.we && wb_req.sel[0];

  assign wb_rsp = '{ack: ack, dat: rd_q};

  always_comb begin
    rdata = '0;
    case (wb_req.adr)
      REG_CTRL: begin
        rdata[CTRL_ENABLE] = run;
      end
      REG_STATUS: begin
        rdata[STATUS_BUSY]     = busy;
        rdata[STATUS_MISMATCH] = mismatch_flag;
      end
      REG_TILES: begin
        rdata = {16'd0, tiles};
      end
      default: begin
        rdata = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= req;
    end
  end

  // Read data goes out together with ack
  always_ff @(posedge clk) begin
    if (req) begin
      rd_q <= wb_req.we ? 32'd0 : rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      run <= 1'b0;
    end else if (wr && wb_req.adr == REG_CTRL) begin
      run <= wb_req.dat[CTRL_ENABLE];
    end
  end

  // Sticky, write one to clear; a new pulse wins over the clear
  always_ff @(posedge clk) begin
    if (rst) begin
      mismatch_flag <= 1'b0;
    end else if (mismatch) begin
      mismatch_flag <= 1'b1;
    end else if (wr && wb_req.adr == REG_STATUS && wb_req.dat[STATUS_MISMATCH]) begin
      mismatch_flag <= 1'b0;
    end
  end

  // Completed tiles, wraps at 16 bits
  always_ff @(posedge clk) begin
    if (rst) begin
      tiles <= '0;
    end else if (tile_done) begin
      tiles <= tiles + 16'd1;
    end
  end

  a_ack_in_cycle: assert property (
    @(posedge clk) disable iff (rst)
    ack |-> (wb_req.cyc && wb_req.stb)
  ) else $error("Wishbone ack outside an active cycle at %0t", $time);

endmodule

`default_nettype wire

// ==== hw/sa_mac_array.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sa_settings.svh"

module sa_mac_array (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  run,
  input  sa_types_pkg::k_beat_t k,
  input  logic                  k_valid,
  output logic                  k_ready,
  input  sa_types_pkg::x_beat_t x,
  input  logic                  x_valid,
  output logic                  x_ready,
  output sa_types_pkg::y_beat_t col,
  output logic                  col_valid,
  input  logic                  col_ready,
  output logic                  busy,
  output logic                  mismatch
);

  import sa_types_pkg::*;

  localparam int CNT_W = (`SA_C > 1) ? $clog2(`SA_C) : 1;

  logic             draining;
  logic             first;
  logic             take;
  logic             accept_ok;
  logic             drain_step;
  logic             drain_done;
  logic [CNT_W-1:0] col_cnt;
  y_elem_t          acc [`SA_R][`SA_C];

  // Join of k and x, both sides see the other's valid
  assign accept_ok = run && !draining;
  assign k_ready   = accept_ok && x_valid;
  assign x_ready   = accept_ok && k_valid;
  assign take      = accept_ok && k_valid && x_valid;

  assign col_valid  = draining;
  assign drain_step = col_valid && col_ready;
  assign drain_done = drain_step && (col_cnt == CNT_W'(`SA_C - 1));

  // Output-stationary grid, one cell per row and column
  for (genvar r = 0; r < `SA_R; r++) begin : g_row
    for (genvar c = 0; c < `SA_C; c++) begin : g_col
      y_elem_t prod;

      assign prod = $signed(x.data[r]) * $signed(k.data[c]);

      always_ff @(posedge clk) begin
        if (take) begin
          if (first) begin
            acc[r][c] <= prod;
          end else begin
            acc[r][c] <= acc[r][c] + prod;
          end
        end
      end
    end
  end

  // Column selected by the drain counter
  always_comb begin
    for (int r = 0; r < `SA_R; r++) begin
      col.data[r] = acc[r][col_cnt];
    end
    col.last = (col_cnt == CNT_W'(`SA_C - 1));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      draining <= 1'b0;
      first    <= 1'b1;
      col_cnt  <= '0;
      busy     <= 1'b0;
      mismatch <= 1'b0;
    end else begin
      mismatch <= take && k.last && (x.last != k.last);
      if (take) begin
        busy  <= 1'b1;
        first <= k.last;
        if (k.last) begin
          draining <= 1'b1;
          col_cnt  <= '0;
        end
      end else if (drain_done) begin
        draining <= 1'b0;
        busy     <= 1'b0;
      end else if (drain_step) begin
        col_cnt <= col_cnt + CNT_W'(1);
      end
    end
  end

  // Tile end locks out operands until its last column has left
  a_no_take_in_drain: assert property (
    @(posedge clk) disable iff (rst)
    (take && k.last) |=>
      ((!(k_valid && k_ready) && !(x_valid && x_ready))
        until_with (col_valid && col_ready && col.last))
  ) else $error("Operand beat accepted during drain at %0t", $time);

endmodule

`default_nettype wire

// ==== hw/sa_regs_pkg.sv ====
`default_nettype none

`include "sa_settings.svh"

package sa_regs_pkg;

  // Register word addresses
  localparam logic [`SA_WB_AW-1:0] REG_CTRL   = `SA_WB_AW'd0;
  localparam logic [`SA_WB_AW-1:0] REG_STATUS = `SA_WB_AW'd1;
  localparam logic [`SA_WB_AW-1:0] REG_TILES  = `SA_WB_AW'd2;

  // Bit positions
  localparam int CTRL_ENABLE     = 0;
  localparam int STATUS_BUSY     = 0;
  localparam int STATUS_MISMATCH = 1;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`SA_WB_AW-1:0] adr;
    logic [31:0]          dat;
    logic [3:0]           sel;
  } wb_req_t;

  // Wishbone classic, slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hw/sa_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module sa_top (
  input  logic                  clk,
  input  logic                  rst,
  input  sa_regs_pkg::wb_req_t  wb_req,
  output sa_regs_pkg::wb_rsp_t  wb_rsp,
  input  sa_types_pkg::k_beat_t k,
  input  logic                  k_valid,
  output logic                  k_ready,
  input  sa_types_pkg::x_beat_t x,
  input  logic                  x_valid,
  output logic                  x_ready,
  input  sa_types_pkg::a_beat_t a,
  input  logic                  a_valid,
  output logic                  a_ready,
  output sa_types_pkg::y_beat_t y,
  output logic                  y_valid,
  input  logic                  y_ready
);

  import sa_types_pkg::*;

  logic    run;
  logic    busy;
  logic    mismatch;
  logic    tile_done;
  y_beat_t col;
  logic    col_valid;
  logic    col_ready;

  // A tile is done when its last output beat leaves
  assign tile_done = y_valid && y_ready && y.last;

  sa_controller ctrl0 (
    .clk       (clk),
    .rst       (rst),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .busy      (busy),
    .mismatch  (mismatch),
    .tile_done (tile_done),
    .run       (run)
  );

  sa_mac_array array0 (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .k         (k),
    .k_valid   (k_valid),
    .k_ready   (k_ready),
    .x         (x),
    .x_valid   (x_valid),
    .x_ready   (x_ready),
    .col       (col),
    .col_valid (col_valid),
    .col_ready (col_ready),
    .busy      (busy),
    .mismatch  (mismatch)
  );

  psum_adder add0 (
    .clk       (clk),
    .rst       (rst),
    .col       (col),
    .col_valid (col_valid),
    .col_ready (col_ready),
    .a         (a),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .y         (y),
    .y_valid   (y_valid),
    .y_ready   (y_ready)
  );

endmodule

`default_nettype wire

// ==== hw/sa_types_pkg.sv ====
`default_nettype none

`include "sa_settings.svh"

package sa_types_pkg;

  // Operand and result elements
  typedef logic signed [`SA_WX-1:0] x_elem_t;
  typedef logic signed [`SA_WK-1:0] k_elem_t;
  typedef logic signed [`SA_WY-1:0] y_elem_t;

  // One pixel row per beat
  typedef struct packed {
    x_elem_t [`SA_R-1:0] data;
    logic                last;
  } x_beat_t;

  // One weight column per beat
  typedef struct packed {
    k_elem_t [`SA_C-1:0] data;
    logic                last;
  } k_beat_t;

  // Partial sums, one per row, no tile marker
  typedef y_elem_t [`SA_R-1:0] a_beat_t;

  // Drained column and final output beat
  typedef struct packed {
    y_elem_t [`SA_R-1:0] data;
    logic                last;
  } y_beat_t;

endpackage

`default_nettype wire

// ==== include/sa_settings.svh ====
`ifndef SA_SETTINGS_SVH
`define SA_SETTINGS_SVH

// Array geometry
`define SA_R 4
`define SA_C 4

// Signed element widths
`define SA_WX 8
`define SA_WK 8

// Accumulator and output width
`define SA_WY 32

// Partial sums entering on the a stream
`define SA_WA 32

// Word address bits on the Wishbone slave
`define SA_WB_AW 4

`endif

// ==== sim/sa_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sa_settings.svh"

module sa_tb;

  import sa_types_pkg::*;
  import sa_regs_pkg::*;

  localparam int WAIT_LIMIT = 200;

  logic        clk;
  logic        rst;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  k_beat_t     k;
  logic        k_valid;
  logic        k_ready;
  x_beat_t     x;
  logic        x_valid;
  logic        x_ready;
  a_beat_t     a;
  logic        a_valid;
  logic        a_ready;
  y_beat_t     y;
  logic        y_valid;
  logic        y_ready;
  logic [15:0] lfsr_state = 16'd70;
  int          checks = 0;
  int          errors = 0;
  k_beat_t     k_q[$];
  x_beat_t     x_q[$];
  a_beat_t     a_q[$];
  y_beat_t     exp_q[$];

  sa_top dut0 (
    .clk     (clk),
    .rst     (rst),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .k       (k),
    .k_valid (k_valid),
    .k_ready (k_ready),
    .x       (x),
    .x_valid (x_valid),
    .x_ready (x_ready),
    .a       (a),
    .a_valid (a_valid),
    .a_ready (a_ready),
    .y       (y),
    .y_valid (y_valid),
    .y_ready (y_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic wb_access(input logic we, input logic [`SA_WB_AW-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat, sel: 4'hf};
    do begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) stop_on_timeout("Wishbone ack");
    end while (!wb_rsp.ack);
    rdat = wb_rsp.dat;
    wb_req <= '0;
  endtask

  task automatic check_reg(input logic [`SA_WB_AW-1:0] adr, input logic [31:0] mask,
                           input logic [31:0] exp, input string what);
    logic [31:0] v;
    wb_access(1'b0, adr, 32'd0, v);
    checks++;
    a_reg_value: assert ((v & mask) == exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s reads %h, expected %h", $time, what, v & mask, exp);
    end
  endtask

  // Reference model builds one expected y beat per column
  task automatic build_tile(input int nbeats, input logic x_last_match);
    k_beat_t kb;
    x_beat_t xb;
    a_beat_t ab;
    y_beat_t yb;
    int      sum [`SA_R][`SA_C];
    for (int r = 0; r < `SA_R; r++) begin
      for (int c = 0; c < `SA_C; c++) begin
        sum[r][c] = 0;
      end
    end
    for (int b = 0; b < nbeats; b++) begin
      for (int c = 0; c < `SA_C; c++) begin
        kb.data[c] = k_elem_t'(rand_bits(`SA_WK));
      end
      for (int r = 0; r < `SA_R; r++) begin
        xb.data[r] = x_elem_t'(rand_bits(`SA_WX));
      end
      kb.last = (b == nbeats - 1);
      xb.last = kb.last && x_last_match;
      for (int r = 0; r < `SA_R; r++) begin
        for (int c = 0; c < `SA_C; c++) begin
          sum[r][c] += int'($signed(xb.data[r])) * int'($signed(kb.data[c]));
        end
      end
      k_q.push_back(kb);
      x_q.push_back(xb);
    end
    for (int c = 0; c < `SA_C; c++) begin
      for (int r = 0; r < `SA_R; r++) begin
        ab[r] = y_elem_t'(rand_bits(`SA_WA));
        yb.data[r] = sum[r][c] + ab[r];
      end
      yb.last = (c == `SA_C - 1);
      a_q.push_back(ab);
      exp_q.push_back(yb);
    end
  endtask

  task automatic send_operands(input int n);
    int waited;
    for (int b = 0; b < n; b++) begin
      k <= k_q.pop_front();
      x <= x_q.pop_front();
      k_valid <= 1'b1;
      x_valid <= 1'b1;
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
        if (waited > WAIT_LIMIT) stop_on_timeout("operand transfer");
      end while (!(k_ready && x_ready));
    end
    k_valid <= 1'b0;
    x_valid <= 1'b0;
  endtask

  task automatic send_psums(input int n);
    int waited;
    for (int b = 0; b < n; b++) begin
      a <= a_q.pop_front();
      a_valid <= 1'b1;
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
        if (waited > WAIT_LIMIT) stop_on_timeout("partial-sum transfer");
      end while (!a_ready);
    end
    a_valid <= 1'b0;
  endtask

  // Random back-pressure on y
  task automatic collect_outputs(input int n);
    int      got;
    int      waited;
    y_beat_t exp;
    got = 0;
    waited = 0;
    y_ready <= (rand_bits(1) != 0);
    while (got < n) begin
      @(posedge clk);
      if (y_valid && y_ready) begin
        exp = exp_q.pop_front();
        checks++;
        a_y_beat: assert (y == exp) else begin
          errors++;
          $display("CHECK FAILED at %0t: y beat %0d is %h, expected %h", $time, got, y, exp);
        end
        got++;
        waited = 0;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) stop_on_timeout("y beat");
      end
      y_ready <= (rand_bits(1) != 0);
    end
    y_ready <= 1'b0;
  endtask

  task automatic run_streams(input int n_ops, input int n_out);
    @(posedge clk);
    fork
      send_operands(n_ops);
      send_psums(n_out);
      collect_outputs(n_out);
    join
  endtask

  a_ack_pulse: assert property (@(posedge clk) disable iff (rst) wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: ack held longer than one cycle", $time);
    end

  a_y_held: assert property (@(posedge clk) disable iff (rst) (y_valid && !y_ready) |=> y_valid)
    else begin
      errors++;
      $display("CHECK FAILED at %0t: y_valid dropped before transfer", $time);
    end

  initial begin
    logic [31:0] unused;
    rst <= 1'b1;
    wb_req <= '0;
    k <= '0;
    k_valid <= 1'b0;
    x <= '0;
    x_valid <= 1'b0;
    a <= '0;
    a_valid <= 1'b0;
    y_ready <= 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // Operands already offered as reset ends
    k_valid <= 1'b1;
    x_valid <= 1'b1;

    @(posedge clk);
    checks++;
    a_reset_idle: assert (!wb_rsp.ack && !y_valid && !k_ready && !x_ready) else begin
      errors++;
      $display("CHECK FAILED at %0t: outputs not idle after reset", $time);
    end
    k_valid <= 1'b0;
    x_valid <= 1'b0;
    check_reg(REG_CTRL, 32'hffff_ffff, 32'd0, "CTRL after reset");
    check_reg(REG_TILES, 32'hffff_ffff, 32'd0, "TILES after reset");

    // Operands offered while the array is disabled
    @(posedge clk);
    k_valid <= 1'b1;
    x_valid <= 1'b1;
    repeat (20) begin
      @(posedge clk);
      checks++;
      a_held_off: assert (!k_ready && !x_ready) else begin
        errors++;
        $display("CHECK FAILED at %0t: operand ready with enable clear", $time);
      end
    end
    k_valid <= 1'b0;
    x_valid <= 1'b0;
    wb_access(1'b1, REG_CTRL, 32'd1 << CTRL_ENABLE, unused);
    check_reg(REG_CTRL, 32'd1 << CTRL_ENABLE, 32'd1 << CTRL_ENABLE, "CTRL enable");

    build_tile(3, 1'b1);
    build_tile(3, 1'b1);
    run_streams(6, 2 * `SA_C);
    check_reg(REG_TILES, 32'hffff_ffff, 32'd2, "TILES after two tiles");
    check_reg(REG_STATUS, 32'd3, 32'd0, "STATUS busy and mismatch");

    // Tile ends disagree on the final beat
    build_tile(3, 1'b0);
    run_streams(3, `SA_C);
    check_reg(REG_STATUS, 32'd1 << STATUS_MISMATCH, 32'd1 << STATUS_MISMATCH, "mismatch set");
    wb_access(1'b1, REG_STATUS, 32'd1 << STATUS_MISMATCH, unused);
    check_reg(REG_STATUS, 32'd1 << STATUS_MISMATCH, 32'd0, "mismatch cleared");
    check_reg(REG_TILES, 32'hffff_ffff, 32'd3, "TILES after mismatch tile");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
